//--- sim.f
+incdir+include
src/jtag_pkg.sv
src/jtag_tck_gen.sv
src/jtag_host.sv
src/jtag_tap.sv
src/jtag_top.sv
tests/jtag_assertions.sv
tests/jtag_tb.sv

//--- Makefile
# Verilator build and run for the JTAG host and target testbench

TOOL       := verilator
TOP        := jtag_tb
FILELIST   := sim.f
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert
RUN_FLAGS  := +verilator+error+limit+100
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: lint sim clean

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# The run passes only when the log holds the pass line
sim:
	$(TOOL) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS) | tee $(LOG)
	grep -q "TB PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tests/jtag_tb.sv
/* Table-driven testbench for the JTAG host and target pair.
   Sends each request, waits for the response and checks it against the target rules */
`timescale 1ns/1ns
`include "jtag_cfg.svh"

module jtag_tb import jtag_pkg::*;
    ;
    localparam int CLK_NS = 8;
    localparam int TCK_CLKS = 2 * (`JTAG_TCK_DIV + 1);
    localparam int MAX_ENTRIES = 16;
    localparam int NUM_RUNS = 19;
    // Twice the plain walk per request leaves room for pause detours and idle gaps
    localparam int WATCHDOG_NS =
        NUM_RUNS * ((12 + 2 * `JTAG_MAX_DR_LEN) * TCK_CLKS * 2 + 40) * CLK_NS;

    localparam ir_word_t IR_CAPTURE = 8'h05;
    localparam ir_word_t INST_IDCODE = ir_word_t'(`JTAG_INST_IDCODE);
    localparam ir_word_t INST_USER = ir_word_t'(`JTAG_INST_USER);
    localparam ir_word_t INST_BYPASS = ir_word_t'(`JTAG_INST_BYPASS);
    localparam ir_word_t INST_UNKNOWN = 8'h07;
    localparam dr_word_t ID_VALUE = dr_word_t'(`JTAG_IDCODE);

    typedef struct packed {
        jtag_req_t  req;
        jtag_resp_t exp;
        logic       poke;
    } test_entry_t;

    logic clk;
    logic reset;
    logic req_valid;
    jtag_req_t req;
    logic busy;
    logic resp_valid;
    jtag_resp_t resp;
    test_entry_t entries [MAX_ENTRIES];
    int num_entries = 0;
    int error_count = 0;
    int check_count = 0;
    int sent_count = 0;
    int resp_count = 0;

    jtag_top i_dut
    (
        .clk        (clk),
        .reset      (reset),
        .req_valid  (req_valid),
        .req        (req),
        .busy       (busy),
        .resp_valid (resp_valid),
        .resp       (resp)
    );

    always #(CLK_NS / 2) clk = !clk;

    always @(posedge clk)
    begin
        if (resp_valid)
            resp_count <= resp_count + 1;
    end

    // A bypass scan returns the input one bit later with a zero in front
    function automatic dr_word_t bypass_result(dr_word_t data, int len);
        return (data << 1) & ~({`JTAG_MAX_DR_LEN{1'b1}} << len);
    endfunction

    task automatic add_entry(input int ir_len, input ir_word_t ir, input int dr_len,
                             input dr_word_t dr, input ir_word_t exp_ir,
                             input dr_word_t exp_dr, input int poke);
        test_entry_t e;
        e.req = '{ir_len: ir_len_t'(ir_len), ir: ir, dr_len: dr_len_t'(dr_len), dr: dr};
        e.exp = '{ir: exp_ir, dr: exp_dr};
        e.poke = poke != 0;
        entries[num_entries] = e;
        num_entries++;
    endtask

    task automatic load_entries();
        add_entry(0, '0, 32, '0, '0, ID_VALUE, 0);
        add_entry(4, INST_IDCODE, 32, 64'h1234_5678, IR_CAPTURE, ID_VALUE, 0);
        add_entry(4, INST_USER, 32, 64'ha5c3_0f96, IR_CAPTURE, '0, 0);
        add_entry(4, INST_USER, 32, 64'h3cd2_7e18, IR_CAPTURE, 64'ha5c3_0f96, 0);
        // Upper half comes back as the low data bits delayed through 32 stages
        add_entry(4, INST_USER, 64, 64'h9182_7364_5546_3728, IR_CAPTURE,
                  64'h5546_3728_3cd2_7e18, 0);
        add_entry(4, INST_BYPASS, 8, 64'hb7, IR_CAPTURE, bypass_result(64'hb7, 8), 0);
        add_entry(4, INST_BYPASS, 64, 64'hf00d_cafe_1234_5678, IR_CAPTURE,
                  bypass_result(64'hf00d_cafe_1234_5678, 64), 0);
        add_entry(4, INST_UNKNOWN, 13, 64'h1abc, IR_CAPTURE, bypass_result(64'h1abc, 13), 0);
        add_entry(4, INST_USER, 32, '0, IR_CAPTURE, 64'h9182_7364, 0);
        add_entry(0, '0, 0, '0, '0, '0, 0);
        add_entry(0, '0, 32, 64'hffff_ffff, '0, ID_VALUE, 0);
        add_entry(4, INST_USER, 0, '0, IR_CAPTURE, '0, 1);
    endtask

    task automatic run_entry(input int idx);
        test_entry_t e;
        int unsigned gap;
        e = entries[idx];
        gap = $urandom % 21;
        repeat (gap) @(negedge clk);
        while (busy)
            @(negedge clk);
        check_count++;
        if (resp_count != sent_count)
        begin
            $display("ERR resp_valid count entry %0d: got %h expected %h",
                     idx, resp_count, sent_count);
            error_count++;
        end
        req = e.req;
        req_valid = 1'b1;
        @(negedge clk);
        req_valid = 1'b0;
        sent_count++;
        check_count++;
        if (!busy)
        begin
            $display("Entry %0d: the request was not taken, busy stayed low", idx);
            error_count++;
        end
        if (e.poke)
        begin
            // Lands while busy is high, so the host must drop it
            repeat (2) @(negedge clk);
            req = '{ir_len: '0, ir: '0, dr_len: dr_len_t'(32), dr: 64'h0bad_f00d};
            req_valid = 1'b1;
            @(negedge clk);
            req_valid = 1'b0;
        end
        while (!resp_valid)
            @(negedge clk);
        check_count += 2;
        if (resp.ir !== e.exp.ir)
        begin
            $display("ERR resp.ir entry %0d: got %h expected %h", idx, resp.ir, e.exp.ir);
            error_count++;
        end
        if (resp.dr !== e.exp.dr)
        begin
            $display("ERR resp.dr entry %0d: got %h expected %h", idx, resp.dr, e.exp.dr);
            error_count++;
        end
        // Step past the pulse so the response counter has caught up
        @(negedge clk);
        if (e.poke)
        begin
            // Long enough for a wrongly taken request to finish a full scan
            repeat ((12 + 2 * `JTAG_MAX_DR_LEN) * TCK_CLKS) @(negedge clk);
            check_count++;
            if (resp_count != sent_count)
            begin
                $display("ERR resp_valid count entry %0d: got %h expected %h",
                         idx, resp_count, sent_count);
                error_count++;
            end
        end
    endtask

    initial
    begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, the DUT stopped answering", WATCHDOG_NS);
        $display("Errors %0d, checks %0d", error_count, check_count);
        $display("TB FAILED");
        $finish;
    end

    initial
    begin
        void'($urandom(32'h51d27896));
        clk = 1'b0;
        reset = 1'b1;
        req_valid = 1'b0;
        req = '0;
        load_entries();
        repeat (5) @(negedge clk);
        reset = 1'b0;

        for (int i = 0; i < num_entries; i++)
            run_entry(i);
        // Same IDCODE, USER and bypass scans again with new gaps and detours
        for (int i = 1; i <= 7; i++)
            run_entry(i);

        repeat (4 * TCK_CLKS) @(negedge clk);
        check_count++;
        if (resp_count != sent_count)
        begin
            $display("ERR resp_valid count at end: got %h expected %h", resp_count, sent_count);
            error_count++;
        end
        $display("Errors %0d, assertion failures %0d, checks %0d", error_count,
                 i_dut.u_assertions.fail_count, check_count);
        if (error_count == 0 && i_dut.u_assertions.fail_count == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

//--- tests/jtag_assertions.sv
/* Concurrent checks on the host pin timing, the response pulse and trst_n.
   Attached to jtag_top with bind */
`timescale 1ns/1ns

module jtag_assertions import jtag_pkg::*;
(
    input logic        clk,
    input logic        reset,
    input logic        busy,
    input logic        resp_valid,
    input logic        tck_fall,
    input jtag_pins_t  pins,
    input jtag_state_t host_state
);
    int unsigned fail_count = 0;

    // Outgoing pins only move in the cycle after a tck fall strobe
    pins_on_fall: assert property (@(posedge clk) disable iff (reset)
        ($changed(pins.tms) || $changed(pins.tdi)) |-> $past(tck_fall))
    else
    begin
        fail_count++;
        $error("tms or tdi changed outside a tck fall cycle");
    end

    resp_with_busy_fall: assert property (@(posedge clk) disable iff (reset)
        resp_valid |-> !busy && $past(busy))
    else
    begin
        fail_count++;
        $error("resp_valid did not come with busy falling");
    end

    resp_one_cycle: assert property (@(posedge clk) disable iff (reset)
        resp_valid |=> !resp_valid)
    else
    begin
        fail_count++;
        $error("resp_valid stayed high for more than one cycle");
    end

    trst_in_reset: assert property (@(posedge clk) disable iff (reset)
        !pins.trst_n |-> host_state == JTAG_RESET)
    else
    begin
        fail_count++;
        $error("trst_n low outside Test-Logic-Reset");
    end

endmodule

bind jtag_top jtag_assertions u_assertions
(
    .clk        (clk),
    .reset      (reset),
    .busy       (busy),
    .resp_valid (resp_valid),
    .tck_fall   (tck_fall),
    .pins       (pins),
    .host_state (u_host.state)
);

//--- src/jtag_top.sv
/* Top level joining the tck divider, the JTAG host and the target TAP.
   Exposes only the request and response side of the host */
`timescale 1ns/1ns

module jtag_top import jtag_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       req_valid,
    input  jtag_req_t  req,
    output logic       busy,
    output logic       resp_valid,
    output jtag_resp_t resp
);
    logic tck;
    logic tck_rise;
    logic tck_fall;
    jtag_pins_t pins;
    logic tdo;

    jtag_tck_gen u_tck_gen
    (
        .clk      (clk),
        .reset    (reset),
        .tck      (tck),
        .tck_rise (tck_rise),
        .tck_fall (tck_fall)
    );

    jtag_host u_host
    (
        .clk        (clk),
        .reset      (reset),
        .tck        (tck),
        .tck_rise   (tck_rise),
        .tck_fall   (tck_fall),
        .req_valid  (req_valid),
        .req        (req),
        .tdo        (tdo),
        .pins       (pins),
        .busy       (busy),
        .resp_valid (resp_valid),
        .resp       (resp)
    );

    jtag_tap u_tap
    (
        .pins  (pins),
        .reset (reset),
        .tdo   (tdo)
    );

endmodule

//--- src/jtag_tap.sv
/* Small JTAG target with a 4-bit instruction register, IDCODE, a 32-bit
   user scratch register and bypass. Clocked directly by tck from the pins */
`timescale 1ns/1ns
`include "jtag_cfg.svh"

module jtag_tap import jtag_pkg::*;
(
    input  jtag_pins_t pins,
    input  logic       reset,
    output logic       tdo
);
    jtag_state_t state;
    tap_inst_t ir_shift;
    tap_inst_t ir_q;
    logic [31:0] dr_shift;
    logic [31:0] scratch;
    logic bypass;
    logic tap_reset;
    logic sel_idcode;
    logic sel_user;

    assign tap_reset = reset || !pins.trst_n;
    assign sel_idcode = ir_q == tap_inst_t'(`JTAG_INST_IDCODE);
    assign sel_user = ir_q == tap_inst_t'(`JTAG_INST_USER);

    always_ff @(posedge pins.tck or posedge tap_reset)
    begin
        if (tap_reset)
        begin
            state <= JTAG_RESET;
            ir_q <= tap_inst_t'(`JTAG_INST_IDCODE);
            scratch <= '0;
        end
        else
        begin
            state <= jtag_next_state(state, pins.tms);
            case (state)
                JTAG_RESET:
                    ir_q <= tap_inst_t'(`JTAG_INST_IDCODE);
                JTAG_UPDATE_IR:
                    ir_q <= ir_shift;
                JTAG_UPDATE_DR:
                begin
                    if (sel_user)
                        scratch <= dr_shift;
                end
                default:
                    ;
            endcase
        end
    end

    // Shift paths, LSB out first with tdi entering at the top
    always_ff @(posedge pins.tck)
    begin
        case (state)
            JTAG_CAPTURE_IR:
                ir_shift <= tap_inst_t'(4'b0101);
            JTAG_SHIFT_IR:
                ir_shift <= {pins.tdi, ir_shift[`JTAG_TAP_IR_LEN - 1:1]};
            JTAG_CAPTURE_DR:
            begin
                bypass <= 1'b0;
                if (sel_idcode)
                    dr_shift <= `JTAG_IDCODE;
                else if (sel_user)
                    dr_shift <= scratch;
            end
            JTAG_SHIFT_DR:
            begin
                bypass <= pins.tdi;
                dr_shift <= {pins.tdi, dr_shift[31:1]};
            end
            default:
                ;
        endcase
    end

    // BYPASS and unknown codes both read through the one-bit register
    always_ff @(negedge pins.tck or posedge tap_reset)
    begin
        if (tap_reset)
            tdo <= 1'b0;
        else if (state == JTAG_SHIFT_IR)
            tdo <= ir_shift[0];
        else if (state == JTAG_SHIFT_DR)
            tdo <= (sel_idcode || sel_user) ? dr_shift[0] : bypass;
        else
            tdo <= 1'b0;
    end

endmodule

//--- src/jtag_host.sv
/* JTAG host. Walks the TAP diagram for one request at a time, shifting IR
   then DR, and returns the bits read back as a single response pulse */
`timescale 1ns/1ns
`include "jtag_cfg.svh"

module jtag_host import jtag_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       tck,
    input  logic       tck_rise,
    input  logic       tck_fall,
    input  logic       req_valid,
    input  jtag_req_t  req,
    input  logic       tdo,
    output jtag_pins_t pins,
    output logic       busy,
    output logic       resp_valid,
    output jtag_resp_t resp
);
    jtag_state_t state;
    logic need_ir;
    logic need_dr;
    logic need_reset;
    dr_len_t count;
    logic [15:0] lfsr;
    logic tms_q;
    logic tdi_q;
    logic trst_n_q;
    logic tms_nxt;
    ir_len_t ir_len_q;
    dr_len_t dr_len_q;
    ir_word_t ir_shift;
    dr_word_t dr_shift;
    logic accept;
    logic resp_done;
    logic rnd_exit;
    logic rnd_pause;
    logic rnd_idle;

    assign busy = need_ir || need_dr || need_reset;
    assign accept = req_valid && !busy;
    assign pins = '{tck: tck, tms: tms_q, tdi: tdi_q, trst_n: trst_n_q};

    // Detour choices only change timing, never what gets shifted
    assign rnd_exit = lfsr[0] && lfsr[5];
    assign rnd_pause = lfsr[1];
    assign rnd_idle = lfsr[2];

    assign resp_done = tck_rise && ((state == JTAG_UPDATE_DR)
        || (state == JTAG_UPDATE_IR && !need_dr)
        || (state == JTAG_SELECT_IR && need_reset));

    // tms for the next tck rise, registered on the fall
    always_comb
    begin
        tms_nxt = 1'b0;
        case (state)
            JTAG_IDLE:       tms_nxt = busy;
            JTAG_SELECT_DR:  tms_nxt = need_ir || need_reset;
            JTAG_CAPTURE_DR,
            JTAG_CAPTURE_IR: tms_nxt = rnd_exit;
            // Last bit always exits, so every walk finishes
            JTAG_SHIFT_DR,
            JTAG_SHIFT_IR:   tms_nxt = (count == dr_len_t'(1)) || rnd_exit;
            JTAG_EXIT1_DR,
            JTAG_EXIT1_IR:   tms_nxt = (count == '0) && !rnd_pause;
            JTAG_PAUSE_DR,
            JTAG_PAUSE_IR:   tms_nxt = !rnd_pause;
            JTAG_EXIT2_DR,
            JTAG_EXIT2_IR:   tms_nxt = (count == '0);
            JTAG_SELECT_IR:  tms_nxt = !need_ir;
            JTAG_UPDATE_IR:  tms_nxt = need_dr && !rnd_idle;
            default:         tms_nxt = 1'b0;
        endcase
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state <= JTAG_RESET;
            need_ir <= 1'b0;
            need_dr <= 1'b0;
            need_reset <= 1'b0;
            count <= '0;
            lfsr <= `JTAG_LFSR_SEED;
            tms_q <= 1'b1;
            tdi_q <= 1'b0;
            trst_n_q <= 1'b0;
            resp_valid <= 1'b0;
        end
        else
        begin
            resp_valid <= resp_done;
            if (accept)
            begin
                need_ir <= req.ir_len != '0;
                need_dr <= req.dr_len != '0;
                need_reset <= req.ir_len == '0 && req.dr_len == '0;
            end

            if (tck_rise)
            begin
                lfsr <= {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
                // The target is held in reset while trst_n is low
                state <= trst_n_q ? jtag_next_state(state, tms_q) : JTAG_RESET;
                case (state)
                    JTAG_CAPTURE_IR: count <= dr_len_t'(ir_len_q);
                    JTAG_CAPTURE_DR: count <= dr_len_q;
                    JTAG_SHIFT_IR,
                    JTAG_SHIFT_DR:   count <= count - dr_len_t'(1);
                    JTAG_UPDATE_IR:  need_ir <= 1'b0;
                    JTAG_UPDATE_DR:  need_dr <= 1'b0;
                    JTAG_SELECT_IR:  need_reset <= 1'b0;
                    default:         ;
                endcase
            end

            if (tck_fall)
            begin
                tms_q <= tms_nxt;
                tdi_q <= (state == JTAG_SHIFT_DR) ? dr_shift[0] : ir_shift[0];
                // Pulse trst_n low for one tck period whenever reset is entered
                trst_n_q <= !(state == JTAG_RESET && trst_n_q);
            end
        end
    end

    // Unused upper bits are masked on load, so a zero length reads back zero
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            ir_len_q <= req.ir_len;
            dr_len_q <= req.dr_len;
            ir_shift <= req.ir & ~({`JTAG_MAX_IR_LEN{1'b1}} << req.ir_len);
            dr_shift <= req.dr & ~({`JTAG_MAX_DR_LEN{1'b1}} << req.dr_len);
        end
        else if (tck_rise)
        begin
            // Returned bits enter at the top of the requested length
            if (state == JTAG_SHIFT_IR)
                ir_shift <= (ir_shift >> 1) | (ir_word_t'(tdo) << (ir_len_q - ir_len_t'(1)));
            if (state == JTAG_SHIFT_DR)
                dr_shift <= (dr_shift >> 1) | (dr_word_t'(tdo) << (dr_len_q - dr_len_t'(1)));
        end

        if (resp_done)
            resp <= '{ir: ir_shift, dr: dr_shift};
    end

endmodule

//--- src/jtag_tck_gen.sv
/* Test clock divider. Produces tck plus one-cycle rise and fall strobes
   in the clk domain so the host can act on tck edges synchronously */
`timescale 1ns/1ns
`include "jtag_cfg.svh"

module jtag_tck_gen
(
    input  logic clk,
    input  logic reset,
    output logic tck,
    output logic tck_rise,
    output logic tck_fall
);
    logic [7:0] count;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            count <= '0;
            tck <= 1'b0;
            tck_rise <= 1'b0;
            tck_fall <= 1'b0;
        end
        else
        begin
            tck_rise <= 1'b0;
            tck_fall <= 1'b0;
            if (count == '0)
            begin
                // Strobes are high in the same cycle as the new tck level
                count <= 8'(`JTAG_TCK_DIV);
                tck <= !tck;
                tck_rise <= !tck;
                tck_fall <= tck;
            end
            else
                count <= count - 8'd1;
        end
    end

endmodule

//--- src/jtag_pkg.sv
/* Types shared by the JTAG host, the target and the test code.
   Holds the TAP state set, request and response words and the pin bundle */
`include "jtag_cfg.svh"

package jtag_pkg;

    typedef enum logic [3:0] {
        JTAG_RESET,
        JTAG_IDLE,
        JTAG_SELECT_DR,
        JTAG_CAPTURE_DR,
        JTAG_SHIFT_DR,
        JTAG_EXIT1_DR,
        JTAG_PAUSE_DR,
        JTAG_EXIT2_DR,
        JTAG_UPDATE_DR,
        JTAG_SELECT_IR,
        JTAG_CAPTURE_IR,
        JTAG_SHIFT_IR,
        JTAG_EXIT1_IR,
        JTAG_PAUSE_IR,
        JTAG_EXIT2_IR,
        JTAG_UPDATE_IR
    } jtag_state_t;

    typedef logic [$clog2(`JTAG_MAX_IR_LEN + 1) - 1:0] ir_len_t;
    typedef logic [$clog2(`JTAG_MAX_DR_LEN + 1) - 1:0] dr_len_t;
    typedef logic [`JTAG_MAX_IR_LEN - 1:0] ir_word_t;
    typedef logic [`JTAG_MAX_DR_LEN - 1:0] dr_word_t;
    typedef logic [`JTAG_TAP_IR_LEN - 1:0] tap_inst_t;

    // Values are right-aligned in their lengths
    typedef struct packed {
        ir_len_t  ir_len;
        ir_word_t ir;
        dr_len_t  dr_len;
        dr_word_t dr;
    } jtag_req_t;

    typedef struct packed {
        ir_word_t ir;
        dr_word_t dr;
    } jtag_resp_t;

    typedef struct packed {
        logic tck;
        logic tms;
        logic tdi;
        logic trst_n;
    } jtag_pins_t;

    // IEEE 1149.1 state diagram, used by both ends so they walk in step
    function automatic jtag_state_t jtag_next_state(jtag_state_t state, logic tms);
        case (state)
            JTAG_RESET:      return tms ? JTAG_RESET : JTAG_IDLE;
            JTAG_IDLE:       return tms ? JTAG_SELECT_DR : JTAG_IDLE;
            JTAG_SELECT_DR:  return tms ? JTAG_SELECT_IR : JTAG_CAPTURE_DR;
            JTAG_CAPTURE_DR: return tms ? JTAG_EXIT1_DR : JTAG_SHIFT_DR;
            JTAG_SHIFT_DR:   return tms ? JTAG_EXIT1_DR : JTAG_SHIFT_DR;
            JTAG_EXIT1_DR:   return tms ? JTAG_UPDATE_DR : JTAG_PAUSE_DR;
            JTAG_PAUSE_DR:   return tms ? JTAG_EXIT2_DR : JTAG_PAUSE_DR;
            JTAG_EXIT2_DR:   return tms ? JTAG_UPDATE_DR : JTAG_SHIFT_DR;
            JTAG_UPDATE_DR:  return tms ? JTAG_SELECT_DR : JTAG_IDLE;
            JTAG_SELECT_IR:  return tms ? JTAG_RESET : JTAG_CAPTURE_IR;
            JTAG_CAPTURE_IR: return tms ? JTAG_EXIT1_IR : JTAG_SHIFT_IR;
            JTAG_SHIFT_IR:   return tms ? JTAG_EXIT1_IR : JTAG_SHIFT_IR;
            JTAG_EXIT1_IR:   return tms ? JTAG_UPDATE_IR : JTAG_PAUSE_IR;
            JTAG_PAUSE_IR:   return tms ? JTAG_EXIT2_IR : JTAG_PAUSE_IR;
            JTAG_EXIT2_IR:   return tms ? JTAG_UPDATE_IR : JTAG_SHIFT_IR;
            JTAG_UPDATE_IR:  return tms ? JTAG_SELECT_DR : JTAG_IDLE;
            default:         return JTAG_RESET;
        endcase
    endfunction

endpackage

//--- include/jtag_cfg.svh
/* Build constants for the JTAG host and target.
   Included by the package and by any module that needs a size or code */
`ifndef JTAG_CFG_SVH
`define JTAG_CFG_SVH

// clk cycles per half tck period, minus one
`define JTAG_TCK_DIV 3

`define JTAG_MAX_IR_LEN 8
`define JTAG_MAX_DR_LEN 64

// Target instruction register width and identification value
`define JTAG_TAP_IR_LEN 4
`define JTAG_IDCODE 32'h4c3a_5e91

`define JTAG_INST_IDCODE 4'h1
`define JTAG_INST_USER 4'h2
`define JTAG_INST_BYPASS 4'hf

// Must be nonzero or the detour LFSR locks up
`define JTAG_LFSR_SEED 16'hace1

`endif
